// File: design/pwo_pkg.sv
// Shared constants and enums of the pointwise polynomial engine, referenced by scoped name
package pwo_pkg;

    // Coefficient format, ML-DSA modulus
    localparam int COEFF_W = 24;
    localparam logic [COEFF_W-1:0] COEFF_Q = 24'd8380417;

    // Polynomial size and memory addressing
    localparam int POLY_N = 256;
    localparam int ADDR_W = 8;

    // Full product of two coefficients
    localparam int PROD_W = 48;

    // Barrett constant floor(2^48 / Q)
    localparam logic [25:0] BARRETT_MU = 26'((64'd1 << PROD_W) / 64'(COEFF_Q));

    // Cycles from a fetch strobe to the matching write strobe into C
    localparam int PIPE_LAT = 4;

    // Pointwise operation selected at start
    typedef enum logic [1:0] {
        PWO_ADD = 2'd0,
        PWO_SUB = 2'd1,
        PWO_MUL = 2'd2
    } pwo_op_e;

    // Address sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_FETCH = 2'd1,
        SEQ_DRAIN = 2'd2
    } seq_state_e;

endpackage

// File: design/coeff_ram.sv
// Simple dual-port coefficient memory with a registered read, instantiated for A, B and C
`timescale 1ns/10ps

module coeff_ram (
    input  logic                        clk,

    // Write port
    input  logic                        wr_en_i,
    input  logic [pwo_pkg::ADDR_W-1:0]  wr_addr_i,
    input  logic [pwo_pkg::COEFF_W-1:0] wr_data_i,

    // Read port
    input  logic                        rd_en_i,
    input  logic [pwo_pkg::ADDR_W-1:0]  rd_addr_i,
    output logic [pwo_pkg::COEFF_W-1:0] rd_data_o
);

    logic [pwo_pkg::COEFF_W-1:0] mem_q [pwo_pkg::POLY_N];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Read data holds between enabled reads
    // A read and a write to one address in the same cycle return the old word
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

// File: design/pwo_sequencer.sv
// Pass controller that latches the operation at start and issues one read address per cycle
`timescale 1ns/10ps

module pwo_sequencer (
    input  logic                       clk,
    input  logic                       rst_n_i,

    // Host command
    input  logic                       start_i,
    input  pwo_pkg::pwo_op_e           op_i,
    input  logic                       acc_i,

    // End of pass from the ALU
    input  logic                       pass_done_i,
    output logic                       busy_o,

    // Fetch stream to the memories and the ALU
    output logic                       fetch_valid_o,
    output logic [pwo_pkg::ADDR_W-1:0] fetch_addr_o,

    // Operation held for the whole pass
    output pwo_pkg::pwo_op_e           op_o,
    output logic                       acc_o
);

    typedef logic [pwo_pkg::ADDR_W-1:0] addr_t;

    pwo_pkg::seq_state_e state_q;
    addr_t               cnt_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= pwo_pkg::SEQ_IDLE;
            cnt_q   <= '0;
            op_o    <= pwo_pkg::PWO_ADD;
            acc_o   <= 1'b0;
        end else begin
            case (state_q)
                pwo_pkg::SEQ_IDLE: begin
                    if (start_i) begin
                        state_q <= pwo_pkg::SEQ_FETCH;
                        cnt_q   <= '0;
                        op_o    <= op_i;
                        acc_o   <= acc_i;
                    end
                end
                pwo_pkg::SEQ_FETCH: begin
                    cnt_q <= cnt_q + addr_t'(1);
                    if (cnt_q == addr_t'(pwo_pkg::POLY_N - 1)) begin
                        state_q <= pwo_pkg::SEQ_DRAIN;
                    end
                end
                pwo_pkg::SEQ_DRAIN: begin
                    // Pipeline still writing the last addresses into C
                    if (pass_done_i) begin
                        state_q <= pwo_pkg::SEQ_IDLE;
                    end
                end
                default: begin
                    state_q <= pwo_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // Busy covers the cycle in which pass_done arrives, since DRAIN is left on it
    assign busy_o        = (state_q != pwo_pkg::SEQ_IDLE);
    assign fetch_valid_o = (state_q == pwo_pkg::SEQ_FETCH);
    assign fetch_addr_o  = cnt_q;

endmodule

// File: design/mod_mult.sv
// Two-stage pipelined Barrett multiplier modulo Q, one operand pair accepted per cycle
`timescale 1ns/10ps

module mod_mult (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic [pwo_pkg::COEFF_W-1:0] a_i,
    input  logic [pwo_pkg::COEFF_W-1:0] b_i,
    output logic [pwo_pkg::COEFF_W-1:0] p_o
);

    logic [pwo_pkg::PROD_W-1:0]                            prod_q;
    logic [pwo_pkg::PROD_W+$bits(pwo_pkg::BARRETT_MU)-1:0] est_full;
    logic [pwo_pkg::COEFF_W-1:0]                           quot;
    logic [pwo_pkg::PROD_W-1:0]                            quot_q;
    logic [pwo_pkg::PROD_W-1:0]                            diff;
    logic [pwo_pkg::COEFF_W+1:0]                           rem;
    logic [pwo_pkg::COEFF_W+1:0]                           rem1;
    logic [pwo_pkg::COEFF_W+1:0]                           rem2;

    // Stage 1, full product
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= a_i * b_i;
        end
    end

    // Quotient estimate is at most two below the true quotient
    // so the remainder stays under 3Q and fits in 26 bits
    always_comb begin
        est_full = prod_q * pwo_pkg::BARRETT_MU;
        quot     = est_full[pwo_pkg::PROD_W +: pwo_pkg::COEFF_W];
        quot_q   = quot * pwo_pkg::COEFF_Q;
        diff     = prod_q - quot_q;
        rem      = diff[pwo_pkg::COEFF_W+1:0];

        if (rem >= {2'b00, pwo_pkg::COEFF_Q}) begin
            rem1 = rem - {2'b00, pwo_pkg::COEFF_Q};
        end else begin
            rem1 = rem;
        end

        if (rem1 >= {2'b00, pwo_pkg::COEFF_Q}) begin
            rem2 = rem1 - {2'b00, pwo_pkg::COEFF_Q};
        end else begin
            rem2 = rem1;
        end
    end

    // Stage 2, reduced result below Q
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            p_o <= '0;
        end else begin
            p_o <= rem2[pwo_pkg::COEFF_W-1:0];
        end
    end

endmodule

// File: design/pwo_alu.sv
// Arithmetic, accumulate and writeback pipeline from the A, B and C read data into memory C
`timescale 1ns/10ps

module pwo_alu (
    input  logic                        clk,
    input  logic                        rst_n_i,

    // Fetch stream from the sequencer
    input  logic                        fetch_valid_i,
    input  logic [pwo_pkg::ADDR_W-1:0]  fetch_addr_i,
    input  pwo_pkg::pwo_op_e            op_i,
    input  logic                        acc_i,

    // Read data, one cycle after the fetch strobe
    input  logic [pwo_pkg::COEFF_W-1:0] a_data_i,
    input  logic [pwo_pkg::COEFF_W-1:0] b_data_i,
    input  logic [pwo_pkg::COEFF_W-1:0] c_data_i,

    // Write port of memory C
    output logic                        wr_en_o,
    output logic [pwo_pkg::ADDR_W-1:0]  wr_addr_o,
    output logic [pwo_pkg::COEFF_W-1:0] wr_data_o,

    output logic                        pass_done_o
);

    localparam int LAST = pwo_pkg::PIPE_LAT - 2;

    typedef logic [pwo_pkg::ADDR_W-1:0] addr_t;

    // Valid and address follow the data, entry 0 is the memory read cycle
    logic [LAST:0]                  vld_q;
    addr_t                          addr_q [LAST+1];

    logic [pwo_pkg::COEFF_W:0]      add_sum;
    logic [pwo_pkg::COEFF_W-1:0]    add_red;
    logic [pwo_pkg::COEFF_W-1:0]    sub_red;
    logic [pwo_pkg::COEFF_W-1:0]    s1_addsub_q;
    logic [pwo_pkg::COEFF_W-1:0]    s1_c_q;
    logic [pwo_pkg::COEFF_W-1:0]    s2_addsub_q;
    logic [pwo_pkg::COEFF_W-1:0]    s2_c_q;
    logic [pwo_pkg::COEFF_W-1:0]    mul_p;
    logic [pwo_pkg::COEFF_W-1:0]    op_res;
    logic [pwo_pkg::COEFF_W:0]      acc_sum;
    logic [pwo_pkg::COEFF_W-1:0]    acc_red;

    // Product runs in parallel with stages 1 and 2
    mod_mult u_mod_mult (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .a_i     (a_data_i),
        .b_i     (b_data_i),
        .p_o     (mul_p)
    );

    // One correction is enough since both operands are below Q
    always_comb begin
        add_sum = {1'b0, a_data_i} + {1'b0, b_data_i};
        if (add_sum >= {1'b0, pwo_pkg::COEFF_Q}) begin
            add_sum = add_sum - {1'b0, pwo_pkg::COEFF_Q};
        end
        add_red = add_sum[pwo_pkg::COEFF_W-1:0];

        // Borrow case wraps back into range modulo 2^24
        if (a_data_i >= b_data_i) begin
            sub_red = a_data_i - b_data_i;
        end else begin
            sub_red = a_data_i - b_data_i + pwo_pkg::COEFF_Q;
        end
    end

    // Stage 3 input, operand result aligned with the product
    always_comb begin
        if (op_i == pwo_pkg::PWO_MUL) begin
            op_res = mul_p;
        end else begin
            op_res = s2_addsub_q;
        end

        acc_sum = {1'b0, op_res};
        if (acc_i) begin
            acc_sum = acc_sum + {1'b0, s2_c_q};
        end
        if (acc_sum >= {1'b0, pwo_pkg::COEFF_Q}) begin
            acc_sum = acc_sum - {1'b0, pwo_pkg::COEFF_Q};
        end
        acc_red = acc_sum[pwo_pkg::COEFF_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q       <= '0;
            wr_en_o     <= 1'b0;
            pass_done_o <= 1'b0;
        end else begin
            vld_q       <= {vld_q[LAST-1:0], fetch_valid_i};
            wr_en_o     <= vld_q[LAST];
            pass_done_o <= wr_en_o && (wr_addr_o == addr_t'(pwo_pkg::POLY_N - 1));
        end
    end

    always_ff @(posedge clk) begin
        addr_q[0] <= fetch_addr_i;
        for (int i = 1; i <= LAST; i++) begin
            addr_q[i] <= addr_q[i-1];
        end

        // Stage 1
        s1_addsub_q <= (op_i == pwo_pkg::PWO_SUB) ? sub_red : add_red;
        s1_c_q      <= c_data_i;

        // Stage 2
        s2_addsub_q <= s1_addsub_q;
        s2_c_q      <= s1_c_q;

        // Stage 3
        wr_addr_o   <= addr_q[LAST];
        wr_data_o   <= acc_red;
    end

endmodule

// File: design/pwo_top.sv
// Top level of the pointwise engine with host load and readback ports around the pass pipeline
`timescale 1ns/10ps

module pwo_top (
    input  logic                        clk,
    input  logic                        rst_n_i,

    // Pass command
    input  logic                        start_i,
    input  pwo_pkg::pwo_op_e            op_i,
    input  logic                        acc_i,

    // Operand load into A or B
    input  logic                        load_we_i,
    input  logic                        load_sel_i,
    input  logic [pwo_pkg::ADDR_W-1:0]  load_addr_i,
    input  logic [pwo_pkg::COEFF_W-1:0] load_data_i,

    // Result readback from C
    input  logic [pwo_pkg::ADDR_W-1:0]  rd_addr_i,
    output logic [pwo_pkg::COEFF_W-1:0] rd_data_o,

    output logic                        busy_o,
    output logic                        done_o
);

    logic                        fetch_valid;
    logic [pwo_pkg::ADDR_W-1:0]  fetch_addr;
    pwo_pkg::pwo_op_e            pass_op;
    logic                        pass_acc;
    logic                        pass_done;

    logic                        load_we;
    logic                        a_we;
    logic                        b_we;
    logic [pwo_pkg::COEFF_W-1:0] a_rd_data;
    logic [pwo_pkg::COEFF_W-1:0] b_rd_data;

    logic                        c_rd_en;
    logic [pwo_pkg::ADDR_W-1:0]  c_rd_addr;
    logic [pwo_pkg::COEFF_W-1:0] c_rd_data;
    logic                        c_wr_en;
    logic [pwo_pkg::ADDR_W-1:0]  c_wr_addr;
    logic [pwo_pkg::COEFF_W-1:0] c_wr_data;

    // Host loads are dropped while a pass is running
    assign load_we = load_we_i && !busy_o;
    assign a_we    = load_we && !load_sel_i;
    assign b_we    = load_we && load_sel_i;

    // C read port belongs to the pass while busy, to the host otherwise
    assign c_rd_en   = busy_o ? fetch_valid : 1'b1;
    assign c_rd_addr = busy_o ? fetch_addr : rd_addr_i;

    assign rd_data_o = c_rd_data;
    assign done_o    = pass_done;

    pwo_sequencer u_seq (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .op_i          (op_i),
        .acc_i         (acc_i),
        .pass_done_i   (pass_done),
        .busy_o        (busy_o),
        .fetch_valid_o (fetch_valid),
        .fetch_addr_o  (fetch_addr),
        .op_o          (pass_op),
        .acc_o         (pass_acc)
    );

    coeff_ram mem_a (
        .clk       (clk),
        .wr_en_i   (a_we),
        .wr_addr_i (load_addr_i),
        .wr_data_i (load_data_i),
        .rd_en_i   (fetch_valid),
        .rd_addr_i (fetch_addr),
        .rd_data_o (a_rd_data)
    );

    coeff_ram mem_b (
        .clk       (clk),
        .wr_en_i   (b_we),
        .wr_addr_i (load_addr_i),
        .wr_data_i (load_data_i),
        .rd_en_i   (fetch_valid),
        .rd_addr_i (fetch_addr),
        .rd_data_o (b_rd_data)
    );

    coeff_ram mem_c (
        .clk       (clk),
        .wr_en_i   (c_wr_en),
        .wr_addr_i (c_wr_addr),
        .wr_data_i (c_wr_data),
        .rd_en_i   (c_rd_en),
        .rd_addr_i (c_rd_addr),
        .rd_data_o (c_rd_data)
    );

    pwo_alu u_alu (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid),
        .fetch_addr_i  (fetch_addr),
        .op_i          (pass_op),
        .acc_i         (pass_acc),
        .a_data_i      (a_rd_data),
        .b_data_i      (b_rd_data),
        .c_data_i      (c_rd_data),
        .wr_en_o       (c_wr_en),
        .wr_addr_o     (c_wr_addr),
        .wr_data_o     (c_wr_data),
        .pass_done_o   (pass_done)
    );

endmodule

// File: tests/pwo_tb.sv
// Self-checking testbench for pwo_top that runs add, subtract and multiply passes against a reference model
`timescale 1ns/10ps

module pwo_tb;

    localparam int N           = pwo_pkg::POLY_N;
    localparam int W           = pwo_pkg::COEFF_W;
    localparam int PASS_CYCLES = pwo_pkg::POLY_N + pwo_pkg::PIPE_LAT + 1;
    localparam int WAIT_LIMIT  = 400;

    logic                       clk;
    logic                       rst_n_i;
    logic                       start_i;
    pwo_pkg::pwo_op_e           op_i;
    logic                       acc_i;
    logic                       load_we_i;
    logic                       load_sel_i;
    logic [pwo_pkg::ADDR_W-1:0] load_addr_i;
    logic [W-1:0]               load_data_i;
    logic [pwo_pkg::ADDR_W-1:0] rd_addr_i;
    logic [W-1:0]               rd_data_o;
    logic                       busy_o;
    logic                       done_o;

    // Shadow copies of the three memories and the expected C of the current pass
    logic [W-1:0] sh_a [N];
    logic [W-1:0] sh_b [N];
    logic [W-1:0] sh_c [N];
    logic [W-1:0] exp_c [N];
    logic [31:0]  rng;

    int err_count;
    int check_count;
    int test_count;
    int test_fail;
    int done_cyc;
    int done_cnt;
    int busy_gap;
    int busy_late;
    logic busy_first;

    pwo_top dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (start_i),
        .op_i        (op_i),
        .acc_i       (acc_i),
        .load_we_i   (load_we_i),
        .load_sel_i  (load_sel_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [W-1:0] rand_coeff();
        rng = xorshift32(rng);
        return W'(rng % 32'(pwo_pkg::COEFF_Q));
    endfunction

    // Expected C entry straight from modular arithmetic on wide integers
    function automatic logic [W-1:0] expected_c(input pwo_pkg::pwo_op_e op, input logic acc,
                                                input logic [W-1:0] a, input logic [W-1:0] b,
                                                input logic [W-1:0] c_old);
        longint q;
        longint r;
        q = longint'(pwo_pkg::COEFF_Q);
        case (op)
            pwo_pkg::PWO_ADD: r = (longint'(a) + longint'(b)) % q;
            pwo_pkg::PWO_SUB: r = (longint'(a) - longint'(b) + q) % q;
            default:          r = (longint'(a) * longint'(b)) % q;
        endcase
        if (acc) begin
            r = (r + longint'(c_old)) % q;
        end
        return W'(r);
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            test_fail++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic load_word(input logic sel, input int addr, input logic [W-1:0] data);
        load_we_i   = 1'b1;
        load_sel_i  = sel;
        load_addr_i = pwo_pkg::ADDR_W'(addr);
        load_data_i = data;
        @(posedge clk);
        #2;
        load_we_i = 1'b0;
    endtask

    task automatic load_operands();
        for (int i = 0; i < N; i++) begin
            sh_a[i] = rand_coeff();
            sh_b[i] = rand_coeff();
        end
        // Corner values at the low addresses where addresses 2 and 3 have B above A
        sh_a[0] = '0;
        sh_b[0] = '0;
        sh_a[1] = pwo_pkg::COEFF_Q - 24'd1;
        sh_b[1] = pwo_pkg::COEFF_Q - 24'd1;
        sh_a[2] = '0;
        sh_b[2] = pwo_pkg::COEFF_Q - 24'd1;
        sh_a[3] = 24'd1;
        sh_b[3] = pwo_pkg::COEFF_Q - 24'd1;
        for (int i = 0; i < N; i++) begin
            load_word(1'b0, i, sh_a[i]);
            load_word(1'b1, i, sh_b[i]);
        end
    endtask

    // Starts a pass and follows it cycle by cycle until ten cycles past done_o
    task automatic run_pass(input pwo_pkg::pwo_op_e op, input logic acc,
                            input int extra_start_cyc, input int load_cyc);
        int cyc;
        for (int i = 0; i < N; i++) begin
            exp_c[i] = expected_c(op, acc, sh_a[i], sh_b[i], sh_c[i]);
        end
        done_cyc   = 0;
        done_cnt   = 0;
        busy_gap   = 0;
        busy_late  = 0;
        busy_first = 1'b0;
        start_i    = 1'b1;
        op_i       = op;
        acc_i      = acc;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        cyc     = 1;
        while (1) begin
            if (cyc == 1) begin
                busy_first = busy_o;
            end
            if (done_o) begin
                done_cnt++;
                if (done_cyc == 0) begin
                    done_cyc = cyc;
                end
            end
            if (done_cyc == 0 || cyc <= done_cyc) begin
                if (!busy_o) begin
                    busy_gap++;
                end
            end else if (busy_o) begin
                busy_late++;
            end
            if (done_cyc != 0 && cyc >= done_cyc + 10) begin
                break;
            end
            if (cyc >= WAIT_LIMIT) begin
                err_count++;
                $display("timeout: done_o did not pulse within %0d cycles of start", WAIT_LIMIT);
                break;
            end
            // Stray commands issued in the middle of the pass
            if (cyc == extra_start_cyc) begin
                start_i = 1'b1;
                op_i    = pwo_pkg::PWO_MUL;
            end else begin
                start_i = 1'b0;
            end
            if (cyc == load_cyc) begin
                load_we_i   = 1'b1;
                load_sel_i  = 1'b0;
                load_addr_i = 8'd5;
                load_data_i = (sh_a[5] == '0) ? 24'd1 : 24'd0;
            end else begin
                load_we_i = 1'b0;
            end
            @(posedge clk);
            #2;
            cyc++;
        end
        start_i   = 1'b0;
        load_we_i = 1'b0;
        check_equal("busy_o one cycle after start", 32'(busy_first), 32'd1);
        check_equal("done_o cycle after start", done_cyc, PASS_CYCLES);
        check_equal("done_o pulse count", done_cnt, 32'd1);
        check_equal("cycles with busy_o low during pass", busy_gap, 32'd0);
        check_equal("cycles with busy_o high after done_o", busy_late, 32'd0);
    endtask

    // Reads back every C entry and compares it with the reference
    task automatic read_and_check();
        for (int i = 0; i < N; i++) begin
            rd_addr_i = pwo_pkg::ADDR_W'(i);
            @(posedge clk);
            #2;
            check_equal($sformatf("C[%0d]", i), {8'd0, rd_data_o}, {8'd0, exp_c[i]});
            sh_c[i] = exp_c[i];
        end
    endtask

    initial begin
        int errs;
        rng         = 32'hd8801d6a;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_fail   = 0;
        rst_n_i     = 1'b0;
        start_i     = 1'b0;
        op_i        = pwo_pkg::PWO_ADD;
        acc_i       = 1'b0;
        load_we_i   = 1'b0;
        load_sel_i  = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        rd_addr_i   = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        errs = err_count;
        @(posedge clk);
        #2;
        check_equal("busy_o after reset", 32'(busy_o), 32'd0);
        check_equal("done_o after reset", 32'(done_o), 32'd0);
        finish_test("idle after reset", errs);

        errs = err_count;
        load_operands();
        run_pass(pwo_pkg::PWO_ADD, 1'b0, 0, 0);
        read_and_check();
        finish_test("add", errs);

        errs = err_count;
        load_operands();
        run_pass(pwo_pkg::PWO_SUB, 1'b0, 0, 0);
        read_and_check();
        finish_test("subtract", errs);

        errs = err_count;
        load_operands();
        run_pass(pwo_pkg::PWO_MUL, 1'b1, 0, 0);
        read_and_check();
        run_pass(pwo_pkg::PWO_ADD, 1'b1, 0, 0);
        read_and_check();
        finish_test("multiply and add with accumulate", errs);

        errs = err_count;
        run_pass(pwo_pkg::PWO_ADD, 1'b0, 100, 0);
        read_and_check();
        finish_test("done timing with start during pass", errs);

        errs = err_count;
        run_pass(pwo_pkg::PWO_MUL, 1'b0, 0, 50);
        read_and_check();
        run_pass(pwo_pkg::PWO_ADD, 1'b0, 0, 0);
        read_and_check();
        finish_test("load during pass", errs);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fail, check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
design/pwo_pkg.sv
design/coeff_ram.sv
design/pwo_sequencer.sv
design/mod_mult.sv
design/pwo_alu.sv
design/pwo_top.sv
tests/pwo_tb.sv

// File: run.sh
#!/bin/sh
# Builds the pointwise engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pwo_tb -f compile.f -o pwo_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/pwo_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^STATUS: PASS$'; then
    exit 0
fi
echo "pass message not found"
exit 1
